// ==== Makefile ====
# Verilator build and run for the sub CPU bus controller

VERILATOR ?= verilator
TOP       ?= subSysCtrl_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f sim.f --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/subSysCtrl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module subSysCtrl_props (
	input logic                CLK_6M,
	input logic                rst,
	input logic                cyc,
	input logic                stb,
	input logic                ack,
	input subBusPkg::extSelect extSel
);

	// Number of failed assertions
	int unsigned failCount = 0;

	// Device selects without the buffer enable
	logic [5:0] devSel;

	assign devSel = {extSel.scr0, extSel.scr1, extSel.obj, extSel.snd, extSel.sPgm, extSel.mPgm};

	////////////////////
	// Bus protocol
	////////////////////

	// Ack only answers a live cycle
	ackInCycle: assert property (@(posedge CLK_6M) disable iff (rst) ack |-> (cyc && stb))
		else begin
			$error("ack seen without cyc and stb");
			failCount++;
		end

	// Ack is a single-cycle pulse
	ackOnePulse: assert property (@(posedge CLK_6M) disable iff (rst) ack |=> !ack)
		else begin
			$error("ack held for more than one cycle");
			failCount++;
		end

	////////////////////
	// Chip selects
	////////////////////

	// Never two devices on the bus at once
	selOneHot: assert property (@(posedge CLK_6M) disable iff (rst) $onehot0(devSel))
		else begin
			$error("more than one chip select active");
			failCount++;
		end

endmodule

bind subSysCtrl subSysCtrl_props props (
	.CLK_6M (CLK_6M),
	.rst    (rst),
	.cyc    (cyc),
	.stb    (stb),
	.ack    (ack),
	.extSel (extSel)
);

`default_nettype wire

// ==== bench/subSysCtrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module subSysCtrl_tb;

	// Frame counter width given to the DUT
	localparam int wdWidth = 4;
	// Frames without a kick before resetOutN drops
	localparam int tripFrames = 1 << (wdWidth - 1);
	localparam int ackTimeout = 16;
	localparam int syncTimeout = 16;

	logic CLK_6M = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [15:0] adr;
	logic [7:0] datW;
	logic [7:0] datR;
	logic ack;
	logic [7:0] extDatR;
	subBusPkg::extSelect extSel;
	subCtrlPkg::videoCtrl video;
	logic clk2H;
	logic vblankN;
	logic mq;
	logic me;
	logic subE;
	logic subQ;
	logic irqN;
	logic resetOutN;

	// 2H divider state
	logic [1:0] divCount = 2'd0;

	int unsigned lcgState = 36;
	int errors = 0;
	int checks = 0;
	int unsigned propFails;

	// Expected latch contents
	subCtrlPkg::videoCtrl videoModel;

	// Results of the last transfer
	subBusPkg::extSelect lastSel;
	logic [7:0] lastDat;

	subSysCtrl #(
		.watchdogWidth (wdWidth)
	) uut (
		.CLK_6M    (CLK_6M),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.datW      (datW),
		.datR      (datR),
		.ack       (ack),
		.extDatR   (extDatR),
		.extSel    (extSel),
		.video     (video),
		.clk2H     (clk2H),
		.vblankN   (vblankN),
		.mq        (mq),
		.me        (me),
		.subE      (subE),
		.subQ      (subQ),
		.irqN      (irqN),
		.resetOutN (resetOutN)
	);

	////////////////////
	// Clocks
	////////////////////

	always #5 CLK_6M = ~CLK_6M;

	// 2H is CLK_6M divided by four
	always @(negedge CLK_6M) divCount <= divCount + 2'd1;
	assign clk2H = divCount[1];

	////////////////////
	// Models
	////////////////////

	function automatic logic [15:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	// Address map in priority order
	function automatic subBusPkg::busRegion predictRegion(logic [15:0] a, logic wr);
		if (a >= 16'h4000 && a <= 16'h43FF)
			return subBusPkg::snd;
		if (a <= 16'h1FFF)
			return subBusPkg::scr0;
		if (a <= 16'h3FFF)
			return subBusPkg::scr1;
		if (a <= 16'h5FFF)
			return subBusPkg::obj;
		if (a <= 16'h7FFF)
			return subBusPkg::sPgm;
		if (wr && a <= 16'h83FF)
			return subBusPkg::wdKick;
		if (wr && a >= 16'h8400 && a <= 16'h87FF)
			return subBusPkg::irqAck;
		if (wr && a >= 16'h8800 && a <= 16'h8FFF)
			return subBusPkg::tileBank;
		if (wr && a >= 16'h9000 && a <= 16'h93FF)
			return subBusPkg::lth0;
		if (wr && a >= 16'h9400 && a <= 16'h97FF)
			return subBusPkg::lth1;
		if (wr && a >= 16'hA000 && a <= 16'hA3FF)
			return subBusPkg::lth2;
		if (!wr)
			return subBusPkg::mPgm;
		return subBusPkg::none;
	endfunction

	function automatic subBusPkg::extSelect expectedSel(subBusPkg::busRegion region);
		subBusPkg::extSelect sel;
		sel = '0;
		case (region)
			subBusPkg::scr0: sel.scr0 = 1'b1;
			subBusPkg::scr1: sel.scr1 = 1'b1;
			subBusPkg::obj:  sel.obj  = 1'b1;
			subBusPkg::snd:  sel.snd  = 1'b1;
			subBusPkg::sPgm: sel.sPgm = 1'b1;
			subBusPkg::mPgm: sel.mPgm = 1'b1;
			default: ;
		endcase
		// Video and sound go through the data buffer
		sel.bufEn = sel.scr0 | sel.scr1 | sel.obj | sel.snd;
		return sel;
	endfunction

	function automatic void updateModel(subBusPkg::busRegion region, logic [15:0] a,
			logic [7:0] d);
		case (region)
			subBusPkg::lth0:     videoModel.lth0[a[subCtrlPkg::latchIndexWidth-1:0]] = d;
			subBusPkg::lth1:     videoModel.lth1[a[subCtrlPkg::latchIndexWidth-1:0]] = d;
			subBusPkg::lth2:     videoModel.backColor = d;
			subBusPkg::tileBank: videoModel.tileBank = d;
			default: ;
		endcase
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic checkSel(string name, subBusPkg::extSelect exp, subBusPkg::extSelect act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkVideo(string name, subCtrlPkg::videoCtrl exp,
			subCtrlPkg::videoCtrl act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkByte(string name, logic [7:0] exp, logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkBit(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	////////////////////
	// Bus tasks
	////////////////////

	// Starts and ends just after a falling edge
	// hold keeps stb up for extra cycles after ack
	task automatic busTransfer(string name, logic [15:0] a, logic wr, logic [7:0] d, int hold);
		int edges;
		logic gotAck;
		subBusPkg::extSelect selBefore;
		edges = 0;
		gotAck = 1'b0;
		selBefore = '0;
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		datW = d;
		while (!gotAck && edges < ackTimeout) begin
			@(posedge CLK_6M);
			@(negedge CLK_6M);
			edges++;
			if (ack)
				gotAck = 1'b1;
			else
				selBefore = extSel;
		end
		if (!gotAck) begin
			errors++;
			$display("%s: no ack within %0d cycles", name, ackTimeout);
		end else begin
			checkByte({name, " ack edges"}, 8'd2, 8'(edges));
			lastSel = selBefore;
			lastDat = datR;
		end
		// Master samples ack on the next edge
		repeat (hold + 1) begin
			@(negedge CLK_6M);
			checkBit({name, " single ack"}, 1'b0, ack);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge CLK_6M);
	endtask

	// One transfer checked against the address map
	task automatic decodeCheck(string label, logic [15:0] a, logic wr, logic [7:0] d);
		string name;
		logic [15:0] r;
		subBusPkg::busRegion region;
		subBusPkg::extSelect sel;
		name = $sformatf("%s %s %h", label, wr ? "write" : "read", a);
		region = predictRegion(a, wr);
		sel = expectedSel(region);
		r = lcgNext();
		extDatR = r[7:0];
		busTransfer(name, a, wr, d, 0);
		checkSel({name, " extSel"}, sel, lastSel);
		if (!wr)
			checkByte({name, " datR"}, (sel & ~7'b0000001) != '0 ? extDatR : 8'hFF, lastDat);
		else
			updateModel(region, a, d);
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (4) @(negedge CLK_6M);
		rst = 1'b0;
		videoModel = '0;
		@(negedge CLK_6M);
	endtask

	task automatic pulseFrame();
		vblankN = 1'b0;
		repeat (4) @(negedge CLK_6M);
		vblankN = 1'b1;
		repeat (4) @(negedge CLK_6M);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic testReset();
		rst = 1'b1;
		repeat (4) @(negedge CLK_6M);
		// Phases are only guaranteed low while reset holds
		checkBit("reset mq", 1'b0, mq);
		checkBit("reset me", 1'b0, me);
		checkBit("reset subE", 1'b0, subE);
		checkBit("reset subQ", 1'b0, subQ);
		rst = 1'b0;
		videoModel = '0;
		@(negedge CLK_6M);
		checkBit("reset ack", 1'b0, ack);
		checkSel("reset extSel", '0, extSel);
		checkVideo("reset latches", '0, video);
		checkBit("reset irqN", 1'b1, irqN);
		checkBit("reset resetOutN", 1'b1, resetOutN);
	endtask

	task automatic testDecode();
		int i;
		logic [15:0] a;
		logic [15:0] r;
		// Top bit is the write flag
		logic [16:0] boundaries[$] = '{
			17'h0_0000, 17'h0_1FFF, 17'h0_2000, 17'h0_3FFF, 17'h0_4000, 17'h0_43FF,
			17'h0_4400, 17'h0_5FFF, 17'h0_6000, 17'h0_7FFF, 17'h0_8000, 17'h0_9000,
			17'h0_FFFF, 17'h1_0000, 17'h1_4000, 17'h1_4400, 17'h1_8000, 17'h1_83FF,
			17'h1_8400, 17'h1_87FF, 17'h1_8800, 17'h1_8FFF, 17'h1_9000, 17'h1_93FF,
			17'h1_9400, 17'h1_97FF, 17'h1_9800, 17'h1_A000, 17'h1_A3FF, 17'h1_A400,
			17'h1_FFFF
		};
		foreach (boundaries[k])
			decodeCheck("edge", boundaries[k][15:0], boundaries[k][16], 8'h5A);
		for (i = 0; i < 40; i++) begin
			a = lcgNext();
			r = lcgNext();
			decodeCheck($sformatf("random %0d", i), a, r[0], r[15:8]);
		end
	endtask

	task automatic testBackPressure();
		busTransfer("held stb", 16'h2000, 1'b0, 8'h00, 3);
		// Next transfer still goes through
		decodeCheck("after hold", 16'h6000, 1'b0, 8'h00);
	endtask

	task automatic testLatches();
		int i;
		logic [15:0] r;
		applyReset();
		for (i = 0; i < 8; i++) begin
			r = lcgNext();
			decodeCheck("lth0", 16'h9000 + 16'(i), 1'b1, r[7:0]);
			decodeCheck("lth1", 16'h9400 + 16'(i), 1'b1, r[15:8]);
		end
		r = lcgNext();
		decodeCheck("backColor", 16'hA000, 1'b1, r[7:0]);
		decodeCheck("tileBank", 16'h8800, 1'b1, r[15:8]);
		checkVideo("latches", videoModel, video);
	endtask

	task automatic testInterrupt();
		int cnt;
		applyReset();
		vblankN = 1'b0;
		cnt = 0;
		while (irqN !== 1'b0 && cnt < syncTimeout) begin
			@(negedge CLK_6M);
			cnt++;
		end
		checks++;
		if (irqN !== 1'b0) begin
			errors++;
			$display("interrupt: irqN did not go low after vblankN fell");
		end
		vblankN = 1'b1;
		repeat (6) @(negedge CLK_6M);
		// Second frame before any acknowledge
		vblankN = 1'b0;
		repeat (6) @(negedge CLK_6M);
		checkBit("irq second frame", 1'b0, irqN);
		decodeCheck("irq ack", 16'h8400, 1'b1, 8'h00);
		checkBit("irq acknowledged", 1'b1, irqN);
		vblankN = 1'b1;
		repeat (4) @(negedge CLK_6M);
	endtask

	task automatic testWatchdog();
		int cnt;
		applyReset();
		repeat (tripFrames - 1) pulseFrame();
		checkBit("watchdog before trip", 1'b1, resetOutN);
		pulseFrame();
		cnt = 0;
		while (resetOutN !== 1'b0 && cnt < syncTimeout) begin
			@(negedge CLK_6M);
			cnt++;
		end
		checks++;
		if (resetOutN !== 1'b0) begin
			errors++;
			$display("watchdog: resetOutN stayed high after %0d frames", tripFrames);
		end
		// Kicked every frame it must never trip
		applyReset();
		repeat (3 * tripFrames) begin
			pulseFrame();
			decodeCheck("kick", 16'h8000, 1'b1, 8'h00);
			checkBit("watchdog kicked", 1'b1, resetOutN);
		end
	endtask

	task automatic testPhases();
		logic prev2H;
		logic now2H;
		@(posedge CLK_6M);
		prev2H = clk2H;
		@(negedge CLK_6M);
		repeat (32) begin
			@(posedge CLK_6M);
			now2H = clk2H;
			@(negedge CLK_6M);
			checkBit("phase mq", now2H, mq);
			checkBit("phase me", prev2H, me);
			checkBit("phase subQ", ~now2H, subQ);
			checkBit("phase subE", ~prev2H, subE);
			prev2H = now2H;
		end
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 16'h0000;
		datW = 8'h00;
		extDatR = 8'h00;
		vblankN = 1'b1;
		testReset();
		testDecode();
		testBackPressure();
		testLatches();
		testInterrupt();
		testWatchdog();
		testPhases();
		propFails = uut.props.failCount;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, propFails);
		if (errors == 0 && propFails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Hard limit on simulation time
	initial begin
		#200000;
		$display("simulation time limit reached");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/accessStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessStage (
	input  logic                 CLK_6M,
	input  logic                 rst,
	input  subBusPkg::decodedReq req,
	input  logic                 valid,
	input  logic [7:0]           extDatR,
	output logic [7:0]           datR,
	output logic                 ack,
	output subBusPkg::extSelect  extSel,
	output subCtrlPkg::videoCtrl video,
	output logic                 done,
	output subBusPkg::busRegion  doneRegion
);

	// Byte within the lth0 or lth1 bank
	logic [subCtrlPkg::latchIndexWidth-1:0] latchIndex;

	// Latch write strobe for this cycle
	logic latchWrite;

	// Read served by an external device
	logic extRead;

	assign latchIndex = req.req.adr[subCtrlPkg::latchIndexWidth-1:0];
	assign latchWrite = valid && req.req.we;
	assign extRead    = !req.req.we && subBusPkg::isExternal(req.region);

	////////////////////
	// Chip selects
	////////////////////

	// Live only while the request is valid
	always_comb begin
		extSel = '0;
		if (valid) begin
			case (req.region)
				subBusPkg::scr0: extSel.scr0 = 1'b1;
				subBusPkg::scr1: extSel.scr1 = 1'b1;
				subBusPkg::obj:  extSel.obj  = 1'b1;
				subBusPkg::snd:  extSel.snd  = 1'b1;
				subBusPkg::sPgm: extSel.sPgm = 1'b1;
				subBusPkg::mPgm: extSel.mPgm = 1'b1;
				default: ;
			endcase
		end
		// Buffer follows the video and sound selects
		extSel.bufEn = extSel.scr0 | extSel.scr1 | extSel.obj | extSel.snd;
	end

	////////////////////
	// Video latches
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			video <= '0;
		end else if (latchWrite) begin
			case (req.region)
				subBusPkg::lth0:     video.lth0[latchIndex] <= req.req.datW;
				subBusPkg::lth1:     video.lth1[latchIndex] <= req.req.datW;
				subBusPkg::lth2:     video.backColor        <= req.req.datW;
				subBusPkg::tileBank: video.tileBank         <= req.req.datW;
				default: ;
			endcase
		end
	end

	////////////////////
	// Response
	////////////////////

	// Read data sampled at the end of the select cycle
	// Unmapped or internal reads float high
	always_ff @(posedge CLK_6M) begin
		if (valid) begin
			datR       <= extRead ? extDatR : 8'hFF;
			doneRegion <= req.region;
		end
	end

	// One-cycle ack, since valid never lasts longer
	always_ff @(posedge CLK_6M) begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= valid;
	end

	// Stage 1 and the IRQ block see completion with the ack
	assign done = ack;

endmodule

`default_nettype wire

// ==== rtl/addrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrDecode (
	input  logic                 CLK_6M,
	input  logic                 rst,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [15:0]          adr,
	input  logic [7:0]           datW,
	input  logic                 done,
	output subBusPkg::decodedReq req,
	output logic                 valid
);

	// Request outstanding until stage 2 answers
	logic held;

	// Blocks a second capture while stb stays high
	logic waitStb;

	// New transfer accepted this edge
	logic capture;

	subBusPkg::busRequest request;

	////////////////////
	// Address map
	////////////////////

	// Priority order matters
	// Sound RAM window sits inside the sprite RAM range and wins
	function automatic subBusPkg::busRegion decodeRegion(logic [15:0] a, logic wr);
		if (a[15:10] == 6'b010000)
			return subBusPkg::snd;
		else if (a[15:13] == 3'b000)
			return subBusPkg::scr0;
		else if (a[15:13] == 3'b001)
			return subBusPkg::scr1;
		else if (a[15:13] == 3'b010)
			return subBusPkg::obj;
		else if (a[15:13] == 3'b011)
			return subBusPkg::sPgm;
		// Write-only control space in the program ROM range
		else if (wr && a[15:10] == 6'b100000)
			return subBusPkg::wdKick;
		else if (wr && a[15:10] == 6'b100001)
			return subBusPkg::irqAck;
		else if (wr && a[15:11] == 5'b10001)
			return subBusPkg::tileBank;
		else if (wr && a[15:10] == 6'b100100)
			return subBusPkg::lth0;
		else if (wr && a[15:10] == 6'b100101)
			return subBusPkg::lth1;
		else if (wr && a[15:10] == 6'b101000)
			return subBusPkg::lth2;
		// Reads anywhere else in the top half hit the main program ROM
		else if (!wr && a[15])
			return subBusPkg::mPgm;
		else
			return subBusPkg::none;
	endfunction

	// Bundle the Wishbone inputs
	assign request = '{adr: adr, datW: datW, we: we};

	// Only one transfer in flight
	assign capture = cyc && stb && !held && !waitStb;

	////////////////////
	// Request register
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (capture) begin
			req.req    <= request;
			req.region <= decodeRegion(adr, we);
		end
	end

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			valid   <= 1'b0;
			held    <= 1'b0;
			waitStb <= 1'b0;
		end else begin
			// Single-cycle hand-off to stage 2
			valid <= capture;
			if (capture)
				held <= 1'b1;
			else if (done)
				held <= 1'b0;
			// Re-arm only once the master drops stb
			if (capture)
				waitStb <= 1'b1;
			else if (!stb)
				waitStb <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/busPhaseGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module busPhaseGen (
	input  logic CLK_6M,
	input  logic rst,
	input  logic clk2H,
	output logic mq,
	output logic me,
	output logic subE,
	output logic subQ
);

	// First stage samples 2H and its complement
	// Bit 1 true phase, bit 0 inverted phase
	logic [1:0] stageQ;

	// Second stage is the first one a clock later
	logic [1:0] stageE;

	////////////////////
	// Delay chain
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			// All phases idle low
			stageQ <= 2'b00;
			stageE <= 2'b00;
		end else begin
			stageQ <= {clk2H, ~clk2H};
			// One CLK_6M behind the Q pair
			stageE <= stageQ;
		end
	end

	// Main CPU Q and E
	assign mq   = stageQ[1];
	assign me   = stageE[1];

	// Sub CPU runs on the complements
	assign subQ = stageQ[0];
	assign subE = stageE[0];

endmodule

`default_nettype wire

// ==== rtl/irqWatchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

module irqWatchdog #(
	parameter int watchdogWidth = 4
) (
	input  logic                CLK_6M,
	input  logic                rst,
	input  logic                vblankN,
	input  logic                done,
	input  subBusPkg::busRegion doneRegion,
	output logic                irqN,
	output logic                resetOutN
);

	// Two sync flops plus one for edge detection
	logic [2:0] vblankSync;

	// Start of vertical blank
	logic vblankFall;

	// Frames since the last kick
	logic [watchdogWidth-1:0] frameCount;

	logic ackWrite;
	logic kickWrite;

	////////////////////
	// VBLANK edge
	////////////////////

	always_ff @(posedge CLK_6M) begin
		// Idle high so reset gives no false edge
		if (rst)
			vblankSync <= 3'b111;
		else
			vblankSync <= {vblankSync[1:0], vblankN};
	end

	assign vblankFall = vblankSync[2] && !vblankSync[1];

	// Completed writes that touch this block
	assign ackWrite  = done && doneRegion == subBusPkg::irqAck;
	assign kickWrite = done && doneRegion == subBusPkg::wdKick;

	////////////////////
	// Interrupt
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst)
			irqN <= 1'b1;
		else if (vblankFall)
			// A new frame beats a late ack
			irqN <= 1'b0;
		else if (ackWrite)
			irqN <= 1'b1;
	end

	////////////////////
	// Watchdog
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst)
			frameCount <= '0;
		else if (kickWrite)
			frameCount <= '0;
		else if (vblankFall && !(&frameCount))
			// Holds at all ones
			frameCount <= frameCount + 1'b1;
	end

	// Top bit trips after half the counter range
	assign resetOutN = !frameCount[watchdogWidth-1];

endmodule

`default_nettype wire

// ==== rtl/subBusPkg.sv ====
`default_nettype none

package subBusPkg;

	////////////////////
	// Wishbone request
	////////////////////

	// One transfer as seen on the CPU side
	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  datW;
		logic        we;
	} busRequest;

	////////////////////
	// Address regions
	////////////////////

	// Region picked by the address map
	// none covers unmapped reads and writes
	typedef enum logic [3:0] {
		scr0,
		scr1,
		obj,
		snd,
		sPgm,
		mPgm,
		tileBank,
		lth0,
		lth1,
		lth2,
		irqAck,
		wdKick,
		none
	} busRegion;

	// Request with its region, handed from stage 1 to stage 2
	typedef struct packed {
		busRequest req;
		busRegion  region;
	} decodedReq;

	// Active-high chip selects to the external devices
	typedef struct packed {
		logic scr0;
		logic scr1;
		logic obj;
		logic snd;
		logic sPgm;
		logic mPgm;
		// Data buffer enable for the video and sound side
		logic bufEn;
	} extSelect;

	// Regions backed by a device outside the controller
	function automatic logic isExternal(busRegion region);
		return region inside {scr0, scr1, obj, snd, sPgm, mPgm};
	endfunction

endpackage

`default_nettype wire

// ==== rtl/subCtrlPkg.sv ====
`default_nettype none

package subCtrlPkg;

	////////////////////
	// Latch geometry
	////////////////////

	// Low address bits that pick one of the scroll/priority bytes
	localparam int latchIndexWidth = 3;

	// Bytes per scroll latch bank
	localparam int latchCount = 1 << latchIndexWidth;

	////////////////////
	// Video control
	////////////////////

	// Write-only latches seen by the video hardware
	// lth0 at 9000h, lth1 at 9400h
	// bytes 3 of each bank carry the ROM bank selects
	typedef struct packed {
		// Scroll and priority for layers 0 and 1
		logic [latchCount-1:0][7:0] lth0;
		// Scroll and priority for layers 2 and 3
		logic [latchCount-1:0][7:0] lth1;
		// Background colour at A000h
		logic [7:0]                 backColor;
		// Tile bank byte at 8800h
		logic [7:0]                 tileBank;
	} videoCtrl;

endpackage

`default_nettype wire

// ==== rtl/subSysCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module subSysCtrl #(
	// Frame counter width, resets after 2^(width-1) frames
	parameter int watchdogWidth = 4
) (
	input  logic                 CLK_6M,
	input  logic                 rst,
	// Wishbone classic slave
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [15:0]          adr,
	input  logic [7:0]           datW,
	output logic [7:0]           datR,
	output logic                 ack,
	// External devices
	input  logic [7:0]           extDatR,
	output subBusPkg::extSelect  extSel,
	output subCtrlPkg::videoCtrl video,
	// Timing
	input  logic                 clk2H,
	input  logic                 vblankN,
	output logic                 mq,
	output logic                 me,
	output logic                 subE,
	output logic                 subQ,
	output logic                 irqN,
	output logic                 resetOutN
);

	// Stage 1 to stage 2
	subBusPkg::decodedReq req;
	logic                 valid;

	// Completion from stage 2
	logic                 done;
	subBusPkg::busRegion  doneRegion;

	////////////////////
	// CPU clock phases
	////////////////////

	busPhaseGen phaseGen (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.clk2H  (clk2H),
		.mq     (mq),
		.me     (me),
		.subE   (subE),
		.subQ   (subQ)
	);

	////////////////////
	// Bus pipeline
	////////////////////

	addrDecode decodeStage (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.datW   (datW),
		.done   (done),
		.req    (req),
		.valid  (valid)
	);

	accessStage access (
		.CLK_6M     (CLK_6M),
		.rst        (rst),
		.req        (req),
		.valid      (valid),
		.extDatR    (extDatR),
		.datR       (datR),
		.ack        (ack),
		.extSel     (extSel),
		.video      (video),
		.done       (done),
		.doneRegion (doneRegion)
	);

	////////////////////
	// IRQ and watchdog
	////////////////////

	irqWatchdog #(
		.watchdogWidth (watchdogWidth)
	) irqWd (
		.CLK_6M     (CLK_6M),
		.rst        (rst),
		.vblankN    (vblankN),
		.done       (done),
		.doneRegion (doneRegion),
		.irqN       (irqN),
		.resetOutN  (resetOutN)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/subBusPkg.sv
rtl/subCtrlPkg.sv
rtl/busPhaseGen.sv
rtl/addrDecode.sv
rtl/accessStage.sv
rtl/irqWatchdog.sv
rtl/subSysCtrl.sv
bench/subSysCtrl_props.sv
bench/subSysCtrl_tb.sv
